//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ttc
FLIST     ?= src.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "sim passed" || (echo "sim failed"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

//--- src.f
ttc_pkg.sv
ttc_prescaler.sv
ttc_counter_lite.sv
ttc_intr_status.sv
ttc_host_if.sv
ttc_timer_top.sv
ttc_assertions.sv
tb_ttc.sv

//--- tb_ttc.sv
`default_nettype none

module tb_ttc;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period      = 20;
  localparam int reset_cycles    = 16;
  localparam int n_random        = 60;
  localparam int max_access      = 200;   // Upper bound over all phases
  localparam int access_cycles   = 8;     // Worst case per four-phase access
  localparam int idle_budget     = 2 * 65600 + 4000;
  localparam int watchdog_cycles = reset_cycles + max_access * access_cycles + idle_budget;

  logic                               pclk26;
  logic                               n_p_reset26;
  logic                               req;
  logic                               we;
  logic [ttc_pkg::ttc_addr_w-1:0]     addr;
  ttc_pkg::ttc_word_u                 wdata;
  logic                               ack;
  logic [ttc_pkg::ttc_data_w-1:0]     rdata;
  logic                               irq;

  logic [31:0] rng;          // xorshift state
  int          error_count;
  logic        s_ack;        // Sampled at negedge
  logic [15:0] s_rdata;

  // Reference model state
  logic        m_ack, m_pen, m_counting, m_hold;
  logic [3:0]  m_pre;
  logic [15:0] m_div, m_interval, m_match_1, m_match_2, m_match_3, m_count, m_rdata;
  logic [6:0]  m_ctrl;
  logic [4:0]  m_status, m_enable;

  ttc_timer_top uut (
    .pclk26(pclk26), .n_p_reset26(n_p_reset26),
    .req(req), .we(we), .addr(addr), .wdata(wdata),
    .ack(ack), .rdata(rdata), .irq(irq)
  );

  initial
  begin
    pclk26 = 1'b0;
    forever #(clk_period / 2) pclk26 = ~pclk26;
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [15:0] rand16();
    rng = xorshift(rng);
    return rng[15:0];
  endfunction

  task automatic fail_run(input string msg);
    error_count++;
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [ttc_pkg::ttc_data_w-1:0] got,
                            input logic [ttc_pkg::ttc_data_w-1:0] exp);
    if (got !== exp)
      fail_run($sformatf("Error at %0t ns: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_status(input logic [ttc_pkg::intr_w-1:0] got,
                              input logic [ttc_pkg::intr_w-1:0] exp);
    if (got !== exp)
      fail_run($sformatf("Error at %0t ns: status got %b expected %b", $time, got, exp));
  endtask

  task automatic check_irq(input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("Error at %0t ns: irq got %b expected %b", $time, got, exp));
  endtask

  task automatic check_ack(input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("Error at %0t ns: ack got %b expected %b", $time, got, exp));
  endtask

  // ------------------------------
  // Cycle model
  // ------------------------------
  task automatic model_reset();
    m_ack      = 0;
    m_pen      = 0;
    m_pre      = 0;
    m_div      = 0;
    m_ctrl     = 7'b0000001;
    m_interval = 0;
    m_match_1  = 0;
    m_match_2  = 0;
    m_match_3  = 0;
    m_count    = 0;
    m_counting = 0;
    m_hold     = 0;
    m_status   = 0;
    m_enable   = 0;
    m_rdata    = 0;
  endtask

  task automatic model_step();
    logic        acc, wr, rd, cen, live, z, hold_old;
    logic [15:0] msk, wrapv, nxt, mux;
    logic [4:0]  pulse;
    hold_old = m_hold;  // Restart hold before this edge
    acc = req & ~m_ack;
    wr  = acc & we;
    rd  = acc & ~we;
    msk = (16'd2 << m_pre) - 16'd1;  // Divide by 2^(N+1)
    cen = m_pen ? ((m_div & msk) == msk) : 1'b1;
    live = m_counting & ~m_ctrl[4] & ~m_ctrl[0];
    z = (m_count == 16'd0);
    pulse[0] = live & z & m_ctrl[1];
    pulse[4] = live & z & ~m_ctrl[1];
    pulse[1] = live & m_ctrl[3] & (m_count == m_match_1);
    pulse[2] = live & m_ctrl[3] & (m_count == m_match_2);
    pulse[3] = live & m_ctrl[3] & (m_count == m_match_3);
    wrapv = m_ctrl[1] ? m_interval : 16'hffff;
    if (m_ctrl[2])
      nxt = (m_count == 16'd0) ? wrapv : m_count - 16'd1;
    else
      nxt = (m_count == wrapv) ? 16'd0 : m_count + 16'd1;
    case (addr)
      4'd0: mux = {11'd0, m_pre, m_pen};
      4'd1: mux = {9'd0, m_ctrl};
      4'd2: mux = m_interval;
      4'd3: mux = m_match_1;
      4'd4: mux = m_match_2;
      4'd5: mux = m_match_3;
      4'd6: mux = m_count;
      4'd7: mux = {11'd0, m_status};
      4'd8: mux = {11'd0, m_enable};
      default: mux = 16'd0;
    endcase
    // Counter runs on the old control values
    if (cen)
    begin
      if (m_ctrl[4])
      begin
        m_count    = !m_ctrl[2] ? 16'd0 : (m_ctrl[1] ? m_interval : 16'hffff);
        m_counting = 0;
        m_hold     = 1;
      end
      else
      begin
        if (!m_ctrl[0])
        begin
          m_count    = nxt;
          m_counting = 1;
        end
        m_hold = 0;
      end
    end
    m_status = (m_status & {5{~(rd && addr == 4'd7)}}) | pulse;
    if (rd) m_rdata = mux;
    m_div = (wr && addr == 4'd0) ? 16'd0 : m_div + 16'd1;
    if (wr && addr == 4'd0) {m_pre, m_pen} = wdata.raw[4:0];
    if (wr && addr == 4'd1)
      m_ctrl = wdata.raw[6:0];
    else if (hold_old)
      m_ctrl[4] = 1'b0;  // Restart self clear
    if (wr && addr == 4'd2) m_interval = wdata.raw;
    if (wr && addr == 4'd3) m_match_1 = wdata.raw;
    if (wr && addr == 4'd4) m_match_2 = wdata.raw;
    if (wr && addr == 4'd5) m_match_3 = wdata.raw;
    if (wr && addr == 4'd8) m_enable = wdata.raw[4:0];
    m_ack = req;
  endtask

  // ------------------------------
  // Bus side
  // ------------------------------
  task automatic cycle();
    @(negedge pclk26);
    s_ack   = ack;
    s_rdata = rdata;
    check_ack(ack, m_ack);
    check_irq(irq, |(m_status & m_enable));
    @(posedge pclk26);
    model_step();
  endtask

  task automatic idle(input int n);
    repeat (n) cycle();
  endtask

  task automatic host_access(input logic w, input logic [3:0] a, input logic [15:0] d,
                             output logic [15:0] v);
    req       <= 1'b1;
    we        <= w;
    addr      <= a;
    wdata.raw <= d;
    do cycle(); while (!s_ack);
    v = s_rdata;
    if (!w && a == ttc_pkg::addr_intr_status)
      check_status(s_rdata[ttc_pkg::intr_w-1:0], m_rdata[ttc_pkg::intr_w-1:0]);
    else if (!w)
      check_word($sformatf("rdata[addr %0d]", a), s_rdata, m_rdata);
    req <= 1'b0;
    we  <= 1'b0;
    do cycle(); while (s_ack);  // Four-phase return to idle
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial
  begin
    logic [15:0] v, a_cnt, iv;
    logic [3:0]  a;
    req = 0;
    we = 0;
    addr = 0;
    wdata = '0;
    n_p_reset26 = 1'b0;
    rng = 32'hcdde;
    error_count = 0;
    model_reset();
    repeat (reset_cycles) @(posedge pclk26);
    n_p_reset26 <= 1'b1;

    // Random access over the whole map
    for (int i = 0; i < n_random; i++)
    begin
      a = 4'(rand16() % 9);
      host_access(rand16() % 2 == 1, a, rand16(), v);
    end

    host_access(1, ttc_pkg::addr_clk_ctrl, 16'h0000, v);     // Prescale off
    host_access(1, ttc_pkg::addr_intr_enable, 16'h001f, v);
    // Overflow up then down over the full range
    for (int dir = 0; dir < 2; dir++)
    begin
      host_access(1, ttc_pkg::addr_cnt_ctrl, 16'h0010 | (16'(dir) << 2), v);
      host_access(0, ttc_pkg::addr_intr_status, 0, v);     // Clear old bits
      idle(65540);
      host_access(0, ttc_pkg::addr_count, 0, v);
      host_access(0, ttc_pkg::addr_intr_status, 0, v);
      if (!v[ttc_pkg::intr_overflow])
        fail_run("Overflow status bit did not set after a full wrap");
    end

    // Interval mode in both directions
    for (int dir = 0; dir < 2; dir++)
    begin
      iv = (rand16() & 16'h00ff) | 16'h0010;
      host_access(1, ttc_pkg::addr_interval, iv, v);
      host_access(1, ttc_pkg::addr_cnt_ctrl, 16'h0012 | (16'(dir) << 2), v);
      for (int k = 0; k < 8; k++)
      begin
        idle(int'(rand16() % 64));
        host_access(0, ttc_pkg::addr_count, 0, v);
        if (v > iv)
          fail_run("Count left the range 0 to interval in interval mode");
      end
      idle(int'(iv) + 2);  // At least one full interval since the restart
      host_access(0, ttc_pkg::addr_intr_status, 0, v);
      if (!v[ttc_pkg::intr_interval])
        fail_run("Interval status bit did not set at zero");
    end

    // Match mode with random matches and enable mask
    host_access(1, ttc_pkg::addr_interval, 16'h0040, v);
    host_access(1, ttc_pkg::addr_match_1, rand16() % 16'h40, v);
    host_access(1, ttc_pkg::addr_match_2, rand16() % 16'h40, v);
    host_access(1, ttc_pkg::addr_match_3, rand16() % 16'h40, v);
    host_access(1, ttc_pkg::addr_intr_enable, rand16() & 16'h001f, v);
    host_access(1, ttc_pkg::addr_cnt_ctrl, 16'h001a, v);
    host_access(0, ttc_pkg::addr_intr_status, 0, v);       // Clear old bits
    idle(200);
    host_access(0, ttc_pkg::addr_intr_status, 0, v);
    if (v[3:1] != 3'b111)
      fail_run("Match status bits did not all set");
    host_access(0, ttc_pkg::addr_intr_status, 0, v);

    // Prescaler with random N
    for (int k = 0; k < 3; k++)
    begin
      host_access(1, ttc_pkg::addr_clk_ctrl, ((rand16() % 4) << 1) | 16'h0001, v);
      host_access(1, ttc_pkg::addr_cnt_ctrl, 16'h0010, v);
      host_access(0, ttc_pkg::addr_count, 0, v);
      idle(int'(rand16() % 100));
      host_access(0, ttc_pkg::addr_count, 0, v);
    end

    // Restart then disable
    host_access(1, ttc_pkg::addr_clk_ctrl, 16'h0000, v);
    host_access(1, ttc_pkg::addr_cnt_ctrl, 16'h0014, v);
    host_access(0, ttc_pkg::addr_count, 0, v);
    host_access(1, ttc_pkg::addr_cnt_ctrl, 16'h0001, v);
    host_access(0, ttc_pkg::addr_intr_status, 0, v);
    host_access(0, ttc_pkg::addr_count, 0, a_cnt);
    idle(50);
    host_access(0, ttc_pkg::addr_count, 0, v);
    if (v != a_cnt)
      fail_run("Count moved while the counter was disabled");
    host_access(0, ttc_pkg::addr_intr_status, 0, v);
    if (v[4:0] != 5'd0)
      fail_run("Status bits set while the counter was disabled");

    if (error_count == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  // Watchdog sized from access count and idle time
  initial
  begin
    #(longint'(watchdog_cycles) * clk_period);
    $display("Watchdog expired before the test sequence completed");
    $display("Finished with errors");
    $fatal(1);
  end

endmodule

`default_nettype wire

//--- ttc_assertions.sv
`default_nettype none

module ttc_assertions (
  input wire logic                          pclk26,
  input wire logic                          n_p_reset26,
  input wire logic                          req,
  input wire logic                          ack,
  input wire logic                          irq,
  input wire logic                          status_rd,
  input wire logic                          enable_sel
);
  timeunit 1ns;
  timeprecision 1ps;

  // ------------------------------
  // Handshake
  // ------------------------------
  ack_rise_needs_req: assert property (
    @(posedge pclk26) disable iff (!n_p_reset26)
    (!req && !ack) |=> !ack)
    else $error("ack rose without req");

  // Held while the host keeps req up
  ack_holds_with_req: assert property (
    @(posedge pclk26) disable iff (!n_p_reset26)
    (req && ack) |=> ack)
    else $error("ack fell while req high");

  // Sticky status keeps irq up until a status read or a mask write
  irq_held_until_clear: assert property (
    @(posedge pclk26) disable iff (!n_p_reset26)
    (irq && !status_rd && !enable_sel) |=> irq)
    else $error("irq dropped without a status read or enable write");

endmodule

bind ttc_timer_top ttc_assertions u_assertions (
  .pclk26(pclk26), .n_p_reset26(n_p_reset26),
  .req(req), .ack(ack), .irq(irq),
  .status_rd(status_rd), .enable_sel(enable_sel)
);

`default_nettype wire

//--- ttc_counter_lite.sv
`default_nettype none

module ttc_counter_lite (
  input  wire logic                              pclk26,
  input  wire logic                              n_p_reset26,
  input  wire logic                              count_en,
  input  wire ttc_pkg::ttc_word_u                wdata,
  input  wire logic                              cnt_ctrl_sel,
  input  wire logic                              interval_sel,
  input  wire logic                              match_1_sel,
  input  wire logic                              match_2_sel,
  input  wire logic                              match_3_sel,
  output logic      [ttc_pkg::ttc_data_w-1:0]    count_val,
  output logic      [6:0]                        cnt_ctrl,
  output logic      [ttc_pkg::ttc_data_w-1:0]    interval,
  output logic      [ttc_pkg::ttc_data_w-1:0]    match_1,
  output logic      [ttc_pkg::ttc_data_w-1:0]    match_2,
  output logic      [ttc_pkg::ttc_data_w-1:0]    match_3,
  output logic      [ttc_pkg::intr_w-1:0]        intr_pulse
);

  logic counting;      // Set once the first count has happened
  logic restart_hold;  // Restart seen, clears the ctrl bit
  logic live;          // Interrupts allowed
  logic at_zero;
  logic [ttc_pkg::ttc_data_w-1:0] wrap_val;    // Top of the count range
  logic [ttc_pkg::ttc_data_w-1:0] count_next;

  // ------------------------------
  // Register writes
  // ------------------------------
  always_ff @(posedge pclk26 or negedge n_p_reset26)
  begin
    if (!n_p_reset26)
    begin
      cnt_ctrl <= 7'b0000001;  // Starts disabled
      interval <= '0;
      match_1  <= '0;
      match_2  <= '0;
      match_3  <= '0;
    end
    else
    begin
      if (cnt_ctrl_sel)
      begin
        cnt_ctrl[ttc_pkg::ctrl_dis]      <= wdata.cnt_ctrl.dis;
        cnt_ctrl[ttc_pkg::ctrl_interval] <= wdata.cnt_ctrl.interval;
        cnt_ctrl[ttc_pkg::ctrl_decr]     <= wdata.cnt_ctrl.decr;
        cnt_ctrl[ttc_pkg::ctrl_match]    <= wdata.cnt_ctrl.match;
        cnt_ctrl[ttc_pkg::ctrl_restart]  <= wdata.cnt_ctrl.restart;
        cnt_ctrl[ttc_pkg::ctrl_wave_dis] <= wdata.cnt_ctrl.wave_dis;
        cnt_ctrl[ttc_pkg::ctrl_wave_pol] <= wdata.cnt_ctrl.wave_pol;
      end
      else if (restart_hold)
        cnt_ctrl[ttc_pkg::ctrl_restart] <= 1'b0;  // Self clear

      if (interval_sel) interval <= wdata.raw;
      if (match_1_sel)  match_1  <= wdata.raw;
      if (match_2_sel)  match_2  <= wdata.raw;
      if (match_3_sel)  match_3  <= wdata.raw;
    end
  end

  // Next count, interval or full 16 bit range
  always_comb
  begin
    wrap_val = cnt_ctrl[ttc_pkg::ctrl_interval] ? interval : '1;
    if (cnt_ctrl[ttc_pkg::ctrl_decr])
      count_next = (count_val == '0) ? wrap_val : count_val - 1'b1;
    else
      count_next = (count_val == wrap_val) ? '0 : count_val + 1'b1;
  end

  // ------------------------------
  // Counter
  // ------------------------------
  always_ff @(posedge pclk26 or negedge n_p_reset26)
  begin
    if (!n_p_reset26)
    begin
      count_val    <= '0;
      counting     <= 1'b0;
      restart_hold <= 1'b0;
    end
    else if (count_en)
    begin
      if (cnt_ctrl[ttc_pkg::ctrl_restart])
      begin
        // Load value depends on direction and mode
        if (!cnt_ctrl[ttc_pkg::ctrl_decr])
          count_val <= '0;
        else if (cnt_ctrl[ttc_pkg::ctrl_interval])
          count_val <= interval;
        else
          count_val <= '1;
        counting     <= 1'b0;
        restart_hold <= 1'b1;
      end
      else
      begin
        if (!cnt_ctrl[ttc_pkg::ctrl_dis])
        begin
          count_val <= count_next;
          counting  <= 1'b1;
        end
        restart_hold <= 1'b0;
      end
    end
  end

  // ------------------------------
  // Interrupt pulses
  // ------------------------------
  assign live    = counting & ~cnt_ctrl[ttc_pkg::ctrl_restart] & ~cnt_ctrl[ttc_pkg::ctrl_dis];
  assign at_zero = (count_val == '0);

  always_comb
  begin
    intr_pulse = '0;
    intr_pulse[ttc_pkg::intr_interval] = live & at_zero & cnt_ctrl[ttc_pkg::ctrl_interval];
    intr_pulse[ttc_pkg::intr_overflow] = live & at_zero & ~cnt_ctrl[ttc_pkg::ctrl_interval];
    // Match compares only in match mode
    intr_pulse[ttc_pkg::intr_match_1] = live & cnt_ctrl[ttc_pkg::ctrl_match] & (count_val == match_1);
    intr_pulse[ttc_pkg::intr_match_2] = live & cnt_ctrl[ttc_pkg::ctrl_match] & (count_val == match_2);
    intr_pulse[ttc_pkg::intr_match_3] = live & cnt_ctrl[ttc_pkg::ctrl_match] & (count_val == match_3);
  end

endmodule

`default_nettype wire

//--- ttc_host_if.sv
`default_nettype none

module ttc_host_if (
  input  wire logic                              pclk26,
  input  wire logic                              n_p_reset26,
  input  wire logic                              req,
  input  wire logic                              we,
  input  wire logic [ttc_pkg::ttc_addr_w-1:0]    addr,
  input  wire ttc_pkg::ttc_word_u                wdata,
  output logic                                   ack,
  output logic      [ttc_pkg::ttc_data_w-1:0]    rdata,
  output ttc_pkg::ttc_word_u                     wr_data,
  output logic                                   clk_ctrl_sel,
  output logic                                   cnt_ctrl_sel,
  output logic                                   interval_sel,
  output logic                                   match_1_sel,
  output logic                                   match_2_sel,
  output logic                                   match_3_sel,
  output logic                                   enable_sel,
  output logic                                   status_rd,
  input  wire logic [ttc_pkg::ttc_data_w-1:0]    clk_ctrl,
  input  wire logic [6:0]                        cnt_ctrl,
  input  wire logic [ttc_pkg::ttc_data_w-1:0]    interval,
  input  wire logic [ttc_pkg::ttc_data_w-1:0]    match_1,
  input  wire logic [ttc_pkg::ttc_data_w-1:0]    match_2,
  input  wire logic [ttc_pkg::ttc_data_w-1:0]    match_3,
  input  wire logic [ttc_pkg::ttc_data_w-1:0]    count_val,
  input  wire logic [ttc_pkg::intr_w-1:0]        status,
  input  wire logic [ttc_pkg::intr_w-1:0]        enable
);

  logic access;  // High in the cycle before the access edge
  logic wr;
  logic [ttc_pkg::ttc_data_w-1:0] rd_mux;

  // ------------------------------
  // Four-phase handshake
  // ------------------------------
  assign access = req & ~ack;
  assign wr     = access & we;

  // ack follows req one edge late
  always_ff @(posedge pclk26 or negedge n_p_reset26)
  begin
    if (!n_p_reset26)
      ack <= 1'b0;
    else
      ack <= req;
  end

  // Write word parked at zero outside a write
  assign wr_data.raw = wr ? wdata.raw : '0;

  // One cycle strobes, read-only addresses have none
  assign clk_ctrl_sel = wr & (addr == ttc_pkg::addr_clk_ctrl);
  assign cnt_ctrl_sel = wr & (addr == ttc_pkg::addr_cnt_ctrl);
  assign interval_sel = wr & (addr == ttc_pkg::addr_interval);
  assign match_1_sel  = wr & (addr == ttc_pkg::addr_match_1);
  assign match_2_sel  = wr & (addr == ttc_pkg::addr_match_2);
  assign match_3_sel  = wr & (addr == ttc_pkg::addr_match_3);
  assign enable_sel   = wr & (addr == ttc_pkg::addr_intr_enable);
  assign status_rd    = access & ~we & (addr == ttc_pkg::addr_intr_status);

  // ------------------------------
  // Read path
  // ------------------------------
  always_comb
  begin
    rd_mux = '0;  // Unmapped reads return 0
    case (addr)
      ttc_pkg::addr_clk_ctrl:    rd_mux      = clk_ctrl;
      ttc_pkg::addr_cnt_ctrl:    rd_mux[6:0] = cnt_ctrl;
      ttc_pkg::addr_interval:    rd_mux      = interval;
      ttc_pkg::addr_match_1:     rd_mux      = match_1;
      ttc_pkg::addr_match_2:     rd_mux      = match_2;
      ttc_pkg::addr_match_3:     rd_mux      = match_3;
      ttc_pkg::addr_count:       rd_mux      = count_val;
      ttc_pkg::addr_intr_status: rd_mux[ttc_pkg::intr_w-1:0] = status;
      ttc_pkg::addr_intr_enable: rd_mux[ttc_pkg::intr_w-1:0] = enable;
      default:                   rd_mux      = '0;
    endcase
  end

  // Held while ack is high
  always_ff @(posedge pclk26 or negedge n_p_reset26)
  begin
    if (!n_p_reset26)
      rdata <= '0;
    else if (access & ~we)
      rdata <= rd_mux;
  end

endmodule

`default_nettype wire

//--- ttc_intr_status.sv
`default_nettype none

module ttc_intr_status (
  input  wire logic                          pclk26,
  input  wire logic                          n_p_reset26,
  input  wire logic [ttc_pkg::intr_w-1:0]    intr_pulse,
  input  wire logic                          enable_sel,
  input  wire ttc_pkg::ttc_word_u            wdata,
  input  wire logic                          status_rd,
  output logic      [ttc_pkg::intr_w-1:0]    status,
  output logic      [ttc_pkg::intr_w-1:0]    enable,
  output logic                               irq
);

  logic [ttc_pkg::intr_w-1:0] keep_mask;  // Zero on a status read

  // ------------------------------
  // Sticky status
  // ------------------------------
  assign keep_mask = {ttc_pkg::intr_w{~status_rd}};

  always_ff @(posedge pclk26 or negedge n_p_reset26)
  begin
    if (!n_p_reset26)
      status <= '0;
    else
      status <= (status & keep_mask) | intr_pulse;  // New pulses survive the read
  end

  // Enable mask
  always_ff @(posedge pclk26 or negedge n_p_reset26)
  begin
    if (!n_p_reset26)
      enable <= '0;
    else if (enable_sel)
      enable <= wdata.raw[ttc_pkg::intr_w-1:0];
  end

  assign irq = |(status & enable);  // Single level interrupt line

endmodule

`default_nettype wire

//--- ttc_pkg.sv
`default_nettype none

package ttc_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int ttc_data_w = 16;
  localparam int ttc_addr_w = 4;

  // Register map, word addressed
  localparam logic [ttc_addr_w-1:0] addr_clk_ctrl    = 4'd0;
  localparam logic [ttc_addr_w-1:0] addr_cnt_ctrl    = 4'd1;
  localparam logic [ttc_addr_w-1:0] addr_interval    = 4'd2;
  localparam logic [ttc_addr_w-1:0] addr_match_1     = 4'd3;
  localparam logic [ttc_addr_w-1:0] addr_match_2     = 4'd4;
  localparam logic [ttc_addr_w-1:0] addr_match_3     = 4'd5;
  localparam logic [ttc_addr_w-1:0] addr_count       = 4'd6; // Read only
  localparam logic [ttc_addr_w-1:0] addr_intr_status = 4'd7; // Read only, clear on read
  localparam logic [ttc_addr_w-1:0] addr_intr_enable = 4'd8;

  // Counter control bits
  localparam int ctrl_dis      = 0; // Disable, active high
  localparam int ctrl_interval = 1; // Interval mode, else overflow
  localparam int ctrl_decr     = 2; // Count down
  localparam int ctrl_match    = 3; // Match compare on
  localparam int ctrl_restart  = 4; // Self clearing
  localparam int ctrl_wave_dis = 5; // Stored only
  localparam int ctrl_wave_pol = 6; // Stored only

  // Interrupt bits
  localparam int intr_interval = 0;
  localparam int intr_match_1  = 1;
  localparam int intr_match_2  = 2;
  localparam int intr_match_3  = 3;
  localparam int intr_overflow = 4;
  localparam int intr_w        = 5;

  // ------------------------------
  // Host write word, three views
  // ------------------------------
  typedef union packed {
    logic [ttc_data_w-1:0] raw;
    struct packed {
      logic [8:0] pad;
      logic       wave_pol;
      logic       wave_dis;
      logic       restart;
      logic       match;
      logic       decr;
      logic       interval;
      logic       dis;           // Bit 0
    } cnt_ctrl;
    struct packed {
      logic [10:0] pad;
      logic [3:0]  prescale;     // Divide by 2^(N+1)
      logic        prescale_en;  // Bit 0
    } clk_ctrl;
  } ttc_word_u;

endpackage

`default_nettype wire

//--- ttc_prescaler.sv
`default_nettype none

module ttc_prescaler (
  input  wire logic                              pclk26,
  input  wire logic                              n_p_reset26,
  input  wire logic                              clk_ctrl_sel,
  input  wire ttc_pkg::ttc_word_u                wdata,
  output logic      [ttc_pkg::ttc_data_w-1:0]    clk_ctrl,
  output logic                                   count_en
);

  logic        prescale_en;  // Divider in use
  logic [3:0]  prescale;     // N
  logic [ttc_pkg::ttc_data_w-1:0] div_cnt;   // Free running divider
  logic [ttc_pkg::ttc_data_w-1:0] div_mask;  // Low N+1 bits set

  // ------------------------------
  // Clock control register
  // ------------------------------
  always_ff @(posedge pclk26 or negedge n_p_reset26)
  begin
    if (!n_p_reset26)
    begin
      prescale_en <= 1'b0;
      prescale    <= 4'd0;
    end
    else if (clk_ctrl_sel)
    begin
      prescale_en <= wdata.clk_ctrl.prescale_en;
      prescale    <= wdata.clk_ctrl.prescale;
    end
  end

  assign clk_ctrl = {11'd0, prescale, prescale_en}; // Read back view

  // Divider restarts on every clk_ctrl write
  always_ff @(posedge pclk26 or negedge n_p_reset26)
  begin
    if (!n_p_reset26)
      div_cnt <= '0;
    else if (clk_ctrl_sel)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  // Thermometer mask, bits 0..N
  always_comb
  begin
    for (int i = 0; i < ttc_pkg::ttc_data_w; i++)
      div_mask[i] = (i <= int'(prescale));
  end

  // One pulse per 2^(N+1) cycles, or every cycle when off
  assign count_en = prescale_en ? ((div_cnt & div_mask) == div_mask) : 1'b1;

endmodule

`default_nettype wire

//--- ttc_timer_top.sv
`default_nettype none

module ttc_timer_top (
  input  wire logic                              pclk26,
  input  wire logic                              n_p_reset26,
  input  wire logic                              req,
  input  wire logic                              we,
  input  wire logic [ttc_pkg::ttc_addr_w-1:0]    addr,
  input  wire ttc_pkg::ttc_word_u                wdata,
  output logic                                   ack,
  output logic      [ttc_pkg::ttc_data_w-1:0]    rdata,
  output logic                                   irq
);

  // ------------------------------
  // Internal nets
  // ------------------------------
  ttc_pkg::ttc_word_u              reg_wdata;  // Write word to the register blocks
  logic clk_ctrl_sel, cnt_ctrl_sel, interval_sel;
  logic match_1_sel, match_2_sel, match_3_sel;
  logic enable_sel, status_rd;
  logic count_en;
  logic [ttc_pkg::ttc_data_w-1:0]  clk_ctrl;
  logic [6:0]                      cnt_ctrl;
  logic [ttc_pkg::ttc_data_w-1:0]  interval, match_1, match_2, match_3, count_val;
  logic [ttc_pkg::intr_w-1:0]      intr_pulse, status, enable;

  ttc_host_if u_host_if (
    .pclk26(pclk26), .n_p_reset26(n_p_reset26),
    .req(req), .we(we), .addr(addr), .wdata(wdata),
    .ack(ack), .rdata(rdata), .wr_data(reg_wdata),
    .clk_ctrl_sel(clk_ctrl_sel), .cnt_ctrl_sel(cnt_ctrl_sel),
    .interval_sel(interval_sel), .match_1_sel(match_1_sel),
    .match_2_sel(match_2_sel), .match_3_sel(match_3_sel),
    .enable_sel(enable_sel), .status_rd(status_rd),
    .clk_ctrl(clk_ctrl), .cnt_ctrl(cnt_ctrl), .interval(interval),
    .match_1(match_1), .match_2(match_2), .match_3(match_3),
    .count_val(count_val), .status(status), .enable(enable)
  );

  ttc_prescaler u_prescaler (
    .pclk26(pclk26), .n_p_reset26(n_p_reset26),
    .clk_ctrl_sel(clk_ctrl_sel), .wdata(reg_wdata),
    .clk_ctrl(clk_ctrl), .count_en(count_en)
  );

  ttc_counter_lite u_counter (
    .pclk26(pclk26), .n_p_reset26(n_p_reset26),
    .count_en(count_en), .wdata(reg_wdata),
    .cnt_ctrl_sel(cnt_ctrl_sel), .interval_sel(interval_sel),
    .match_1_sel(match_1_sel), .match_2_sel(match_2_sel), .match_3_sel(match_3_sel),
    .count_val(count_val), .cnt_ctrl(cnt_ctrl), .interval(interval),
    .match_1(match_1), .match_2(match_2), .match_3(match_3),
    .intr_pulse(intr_pulse)
  );

  ttc_intr_status u_intr_status (
    .pclk26(pclk26), .n_p_reset26(n_p_reset26),
    .intr_pulse(intr_pulse), .enable_sel(enable_sel),
    .wdata(reg_wdata), .status_rd(status_rd),
    .status(status), .enable(enable), .irq(irq)
  );

endmodule

`default_nettype wire
